// File: all.f
hw/bus_types_pkg.sv
hw/ifetch_arbiter.sv
hw/coherence_control.sv
hw/ram_port_mux.sv
hw/ram_model.sv
hw/memory_system.sv
tests/clock_gen.sv
tests/coherence_chk.sv
tests/memory_system_tb.sv

// File: hw/bus_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word and address types, per-core port structs
// ram request struct and ram status enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bus_types_pkg;

   parameter int CPUS = 2; // number of cores on the bus

   typedef logic [31:0] word_t; // one data word
   typedef logic [31:0] addr_t; // word address, ports and ram alike

   // ACCESS means the ram completes the access this cycle
   typedef enum logic [1:0] {FREE, BUSY, ACCESS, ERROR} ram_state_t;

   typedef struct packed {
      logic  iren;   // instruction read enable
      addr_t iaddr;
   } ireq_t;

   typedef struct packed {
      logic  iwait;  // low for the one cycle iload is valid
      word_t iload;
   } iresp_t;

   typedef struct packed {
      logic  dren;
      logic  dwen;
      addr_t daddr;
      word_t dstore; // also carries the writeback block on a snoop hit
   } dreq_t;

   typedef struct packed {
      logic  dwait;
      word_t dload;
   } dresp_t;

   // cache answer to a snoop
   typedef struct packed {
      logic cctrans; // still changing state
      logic ccwrite; // block is modified, writing it back
   } snoop_in_t;

   typedef struct packed {
      logic  ccwait;      // hold the cache while another core is served
      logic  ccinv;       // invalidate the snooped block
      addr_t ccsnoopaddr;
   } snoop_out_t;

   typedef struct packed {
      logic  ramren;
      logic  ramwen;
      addr_t ramaddr;
      word_t ramstore;
   } ram_req_t;

endpackage

// File: hw/coherence_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coherence controller for the data ports
// snoop FSM, memory serve and cache to cache serve
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coherence_control (
   input  logic                       CLK,
   input  logic                       nRST,
   input  bus_types_pkg::dreq_t       dreq [bus_types_pkg::CPUS],
   input  bus_types_pkg::snoop_in_t   snoop_in [bus_types_pkg::CPUS],
   input  bus_types_pkg::ram_state_t  ram_state,
   input  bus_types_pkg::word_t       ram_load,
   output bus_types_pkg::ram_req_t    dram_req,
   output bus_types_pkg::dresp_t      dresp [bus_types_pkg::CPUS],
   output bus_types_pkg::snoop_out_t  snoop_out [bus_types_pkg::CPUS],
   output logic                       data_busy
);
   import bus_types_pkg::*;

   // the digit names the requesting core
   // CACHEn means the other cache owns the block and forwards it to core n
   // MEMn means ram owns the block
   typedef enum logic [2:0] {
      IDLE,
      ARBITRATE,
      SNOOP0,
      SNOOP1,
      CACHE0,
      CACHE1,
      MEM0,
      MEM1
   } state_t;

   state_t state, next_state;

   logic [CPUS-1:0] want; // per-core data request pending
   logic rq;              // requesting core
   logic ot;              // the other core, the one being snooped
   logic in_cache;        // cache to cache serve in progress
   logic served_q;        // requester already got its word in this serve

   always_comb begin
      for (int i = 0; i < CPUS; i++) begin
         want[i] = dreq[i].dren | dreq[i].dwen;
      end
   end

   // requester id falls out of the state name
   assign rq        = (state == SNOOP1) || (state == CACHE1) || (state == MEM1);
   assign ot        = !rq;
   assign in_cache  = (state == CACHE0) || (state == CACHE1);
   assign data_busy = (state != IDLE); // mux hands ram to this side

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state    <= IDLE;
         served_q <= 1'b0;
      end else begin
         state    <= next_state;
         served_q <= in_cache; // low only in the first serve cycle
      end
   end

   always_comb begin : next_state_logic
      next_state = state;
      case (state)
         IDLE: begin
            if (|want) begin
               next_state = ARBITRATE;
            end
         end
         ARBITRATE: begin
            if (want[0]) begin
               next_state = SNOOP0; // core 0 wins ties
            end else if (want[1]) begin
               next_state = SNOOP1;
            end else begin
               next_state = IDLE;
            end
         end
         SNOOP0, SNOOP1: begin
            if (snoop_in[ot].cctrans) begin
               next_state = state; // snooped cache still deciding
            end else if (snoop_in[ot].ccwrite) begin
               next_state = rq ? CACHE1 : CACHE0; // modified copy found
            end else begin
               next_state = rq ? MEM1 : MEM0;
            end
         end
         CACHE0, CACHE1, MEM0, MEM1: begin
            if (ram_state == ACCESS) begin
               next_state = IDLE; // writeback or own access landed
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   always_comb begin : output_logic
      // quiet bus unless a state says otherwise
      for (int i = 0; i < CPUS; i++) begin
         dresp[i].dwait           = 1'b1;
         dresp[i].dload           = '0;
         snoop_out[i].ccwait      = 1'b0;
         snoop_out[i].ccinv       = 1'b0;
         snoop_out[i].ccsnoopaddr = '0;
      end
      dram_req = '0;

      case (state)
         ARBITRATE: begin
            // freeze both caches while picking a winner
            for (int i = 0; i < CPUS; i++) begin
               snoop_out[i].ccwait = 1'b1;
            end
         end
         SNOOP0, SNOOP1: begin
            snoop_out[ot].ccwait      = 1'b1;
            snoop_out[ot].ccsnoopaddr = dreq[rq].daddr;
            snoop_out[ot].ccinv       = dreq[rq].dwen; // writer takes exclusive copy
         end
         CACHE0, CACHE1: begin
            snoop_out[ot].ccwait      = 1'b1;
            snoop_out[ot].ccsnoopaddr = dreq[rq].daddr;
            // dirty block goes to requester now and to ram in parallel
            dresp[rq].dload           = dreq[ot].dstore;
            dresp[rq].dwait           = served_q;
            dram_req.ramwen           = 1'b1;
            dram_req.ramaddr          = dreq[rq].daddr;
            dram_req.ramstore         = dreq[ot].dstore;
            dresp[ot].dwait           = (ram_state != ACCESS); // writeback done
         end
         MEM0, MEM1: begin
            // requester's own access straight to ram
            dram_req.ramren   = dreq[rq].dren;
            dram_req.ramwen   = dreq[rq].dwen;
            dram_req.ramaddr  = dreq[rq].daddr;
            dram_req.ramstore = dreq[rq].dstore;
            dresp[rq].dload   = ram_load;
            dresp[rq].dwait   = (ram_state != ACCESS);
         end
         default: begin
            dram_req = '0; // IDLE leaves the ram to fetches
         end
      endcase
   end

endmodule

// File: hw/ifetch_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch arbiter
// core 0 first, with a held grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ifetch_arbiter (
   input  logic                       CLK,
   input  logic                       nRST,
   input  bus_types_pkg::ireq_t       ireq [bus_types_pkg::CPUS],
   input  bus_types_pkg::ram_state_t  ram_state,
   input  bus_types_pkg::word_t       ram_load,
   output bus_types_pkg::ram_req_t    iram_req,
   output bus_types_pkg::iresp_t      iresp [bus_types_pkg::CPUS]
);
   import bus_types_pkg::*;

   logic sel;     // core that owns the ram port this cycle
   logic grant_q; // core whose fetch is in flight
   logic lock_q;  // a fetch is in flight, keep its grant

   // an open fetch keeps its core, else core 0 wins when it reads
   assign sel = lock_q ? grant_q : !ireq[0].iren;

   always_comb begin
      iram_req.ramren   = ireq[sel].iren;
      iram_req.ramwen   = 1'b0; // fetches never write
      iram_req.ramaddr  = ireq[sel].iaddr;
      iram_req.ramstore = '0;
   end

   // only the granted core sees its word, and only at ACCESS
   always_comb begin
      for (int i = 0; i < CPUS; i++) begin
         iresp[i].iwait = !((i == int'(sel)) && ireq[i].iren && (ram_state == ACCESS));
         iresp[i].iload = (i == int'(sel)) ? ram_load : '0;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         lock_q  <= 1'b0;
         grant_q <= 1'b0;
      end else if (ireq[sel].iren && (ram_state != ACCESS)) begin
         lock_q  <= 1'b1; // fetch started or still waiting
         grant_q <= sel;
      end else begin
         lock_q  <= 1'b0; // done or nobody reading
      end
   end

endmodule

// File: hw/memory_system.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem top level
// fetch arbiter, coherence control, ram mux, ram
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_system #(
   parameter int RAM_LAT   = 2,
   parameter int RAM_WORDS = 256
) (
   input  logic                       CLK,
   input  logic                       nRST,
   input  bus_types_pkg::ireq_t       ireq [bus_types_pkg::CPUS],
   output bus_types_pkg::iresp_t      iresp [bus_types_pkg::CPUS],
   input  bus_types_pkg::dreq_t       dreq [bus_types_pkg::CPUS],
   output bus_types_pkg::dresp_t      dresp [bus_types_pkg::CPUS],
   input  bus_types_pkg::snoop_in_t   snoop_in [bus_types_pkg::CPUS],
   output bus_types_pkg::snoop_out_t  snoop_out [bus_types_pkg::CPUS]
);
   import bus_types_pkg::*;

   ram_req_t   iram_req, dram_req, ram_req;
   ram_state_t ram_state, iram_state, dram_state;
   word_t      ram_load;   // shared by both sides, only the granted one looks
   logic       data_busy;  // data side holds the ram

   ifetch_arbiter u_ifetch (
      .CLK(CLK), .nRST(nRST),
      .ireq(ireq), .ram_state(iram_state), .ram_load(ram_load),
      .iram_req(iram_req), .iresp(iresp)
   );

   coherence_control u_coh (
      .CLK(CLK), .nRST(nRST),
      .dreq(dreq), .snoop_in(snoop_in),
      .ram_state(dram_state), .ram_load(ram_load),
      .dram_req(dram_req), .dresp(dresp), .snoop_out(snoop_out),
      .data_busy(data_busy)
   );

   ram_port_mux u_mux (
      .data_busy(data_busy), .iram_req(iram_req), .dram_req(dram_req),
      .ram_state(ram_state), .iram_state(iram_state), .dram_state(dram_state),
      .ram_req(ram_req)
   );

   ram_model #(.RAM_LAT(RAM_LAT), .RAM_WORDS(RAM_WORDS)) u_ram (
      .CLK(CLK), .nRST(nRST),
      .ram_req(ram_req), .ram_load(ram_load), .ram_state(ram_state)
   );

endmodule

// File: hw/ram_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word addressed backing ram
// fixed latency counter and ram_state output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ram_model #(
   parameter int RAM_LAT   = 2,   // cycles from request to ACCESS
   parameter int RAM_WORDS = 256
) (
   input  logic                       CLK,
   input  logic                       nRST,
   input  bus_types_pkg::ram_req_t    ram_req,
   output bus_types_pkg::word_t       ram_load,
   output bus_types_pkg::ram_state_t  ram_state
);
   import bus_types_pkg::*;

   localparam int AW = $clog2(RAM_WORDS);
   localparam int CW = $clog2(RAM_LAT + 1);

   word_t         mem [RAM_WORDS];
   ram_req_t      req_q;    // last cycle's request, spots a new one
   logic [CW-1:0] cnt_q;    // cycles spent on the current request
   logic [CW-1:0] elapsed;
   logic          rest_q;   // the FREE cycle after ACCESS
   logic          active;
   logic          fresh;
   logic          in_range;
   logic [AW-1:0] idx;

   assign active   = ram_req.ramren | ram_req.ramwen;
   assign fresh    = (ram_req != req_q); // new or switched request restarts
   assign elapsed  = fresh ? '0 : cnt_q;
   assign in_range = (ram_req.ramaddr < addr_t'(RAM_WORDS));
   assign idx      = ram_req.ramaddr[AW-1:0];
   assign ram_load = mem[idx];           // valid when ACCESS shows

   always_comb begin
      if (!active || rest_q) begin
         ram_state = FREE;
      end else if (!in_range) begin
         ram_state = ERROR; // address past the end
      end else if (elapsed == CW'(RAM_LAT)) begin
         ram_state = ACCESS;
      end else begin
         ram_state = BUSY;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         req_q  <= '0;
         cnt_q  <= '0;
         rest_q <= 1'b0;
      end else begin
         req_q <= ram_req;
         if (ram_state == ACCESS) begin
            rest_q <= 1'b1;
            cnt_q  <= '0;
         end else if (ram_state == BUSY) begin
            rest_q <= 1'b0;
            cnt_q  <= elapsed + 1'b1;
         end else begin
            rest_q <= 1'b0; // held request counts again from here
            cnt_q  <= '0;
         end
      end
   end

   // every word starts out holding its own address
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] <= word_t'(i);
         end
      end else if ((ram_state == ACCESS) && ram_req.ramwen) begin
         mem[idx] <= ram_req.ramstore;
      end
   end

endmodule

// File: hw/ram_port_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ram port mux, data side first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ram_port_mux (
   input  logic                       data_busy,
   input  bus_types_pkg::ram_req_t    iram_req,
   input  bus_types_pkg::ram_req_t    dram_req,
   input  bus_types_pkg::ram_state_t  ram_state,
   output bus_types_pkg::ram_state_t  iram_state,
   output bus_types_pkg::ram_state_t  dram_state,
   output bus_types_pkg::ram_req_t    ram_req
);
   import bus_types_pkg::*;

   // the coherence controller owns the ram for its whole transaction,
   // fetches only get through while it sits in IDLE
   always_comb begin
      if (data_busy) begin
         ram_req    = dram_req;
         dram_state = ram_state;
         iram_state = BUSY;      // fetch side stalls
      end else begin
         ram_req    = iram_req;
         iram_state = ram_state;
         dram_state = BUSY;      // nothing pending on data side anyway
      end
   end

endmodule

// File: run.sh
#!/bin/bash
# build and run the memory_system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module memory_system_tb -f all.f -o sim_memory_system
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out="$(./obj_dir/sim_memory_system)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
   exit 0
fi
exit 1

// File: tests/clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock, 20 ns period
// reset held low for 16 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clock_gen (
   output logic CLK,
   output logic nRST
);
   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   initial begin
      nRST = 1'b0;
      repeat (16) @(posedge CLK);
      nRST <= 1'b1; // release on an edge
   end

endmodule

// File: tests/coherence_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake assertions, bound to coherence_control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module coherence_chk (
   input logic                       CLK,
   input logic                       nRST,
   input bus_types_pkg::dresp_t      dresp [bus_types_pkg::CPUS],
   input bus_types_pkg::snoop_out_t  snoop_out [bus_types_pkg::CPUS],
   input logic                       in_cache
);
   // both data ports finish together only in a cache to cache serve
   dual_dwait: assert property (@(posedge CLK) disable iff (!nRST)
      (dresp[0].dwait || dresp[1].dwait || in_cache))
      else $error("both dwait low outside cache to cache serve");

   // invalidate only while the cache is held
   inv0_held: assert property (@(posedge CLK) disable iff (!nRST)
      !(snoop_out[0].ccinv && !snoop_out[0].ccwait))
      else $error("ccinv to core 0 without ccwait");
   inv1_held: assert property (@(posedge CLK) disable iff (!nRST)
      !(snoop_out[1].ccinv && !snoop_out[1].ccwait))
      else $error("ccinv to core 1 without ccwait");

endmodule

bind coherence_control coherence_chk u_chk (
   .CLK(CLK), .nRST(nRST), .dresp(dresp), .snoop_out(snoop_out), .in_cache(in_cache)
);

// File: tests/memory_system_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory_system testbench
// plays both caches, holds the ram model
// lfsr stimulus and compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_system_tb;
   import bus_types_pkg::*;

   logic CLK, nRST;
   ireq_t ireq [CPUS];
   iresp_t iresp [CPUS];
   dreq_t dreq [CPUS];
   dresp_t dresp [CPUS];
   snoop_in_t snoop_in [CPUS];
   snoop_out_t snoop_out [CPUS];

   logic [31:0] lfsr = 32'hb04f_0276;
   word_t ram_m [128];        // ram copy, words 64..127 only fetched in mixed test
   logic  dbit [CPUS][64];    // modified blocks per cache
   word_t dval [CPUS][64];
   int errors = 0, checks = 0, test_errs = 0, issued = 0, cycles = 0;

   clock_gen u_clk (.CLK(CLK), .nRST(nRST));

   memory_system #(.RAM_LAT(2), .RAM_WORDS(256)) dut (
      .CLK(CLK), .nRST(nRST), .ireq(ireq), .iresp(iresp), .dreq(dreq),
      .dresp(dresp), .snoop_in(snoop_in), .snoop_out(snoop_out)
   );

   // galois lfsr, one step per bit taken
   function automatic int rnd(input int n);
      int v;
      v = 0;
      for (int k = 0; k < n; k++) begin
         v = (v << 1) | int'(lfsr[0]);
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report(input string name);
      $display("test %s: %0d errors", name, test_errs);
      test_errs = 0;
   endtask

   // fetch from the cores in mask
   // core 1 starts lead cycles ahead of core 0 and then keeps its grant
   task automatic ifetch(input logic [1:0] mask, input int lead, input addr_t a0,
                         input addr_t a1);
      logic [1:0] done;
      logic [1:0] started;
      addr_t a [CPUS];
      int t [CPUS];
      int cyc;
      done = ~mask;
      started = ~mask;
      a[0] = a0;
      a[1] = a1;
      cyc = 0;
      t[0] = 0;
      t[1] = 0;
      @(posedge CLK);
      while (done != 2'b11) begin
         for (int i = 0; i < CPUS; i++) begin
            if (!started[i] && ((i == 1) || (cyc >= lead))) begin
               ireq[i] <= '{iren: 1'b1, iaddr: a[i]};
               started[i] = 1'b1;
               issued++;
            end else if (done[i] && mask[i]) begin
               ireq[i] <= '0;
            end
         end
         @(negedge CLK); // outputs settled
         cyc++;
         for (int i = 0; i < CPUS; i++) begin
            if (!done[i] && !iresp[i].iwait) begin
               check_word("iload", iresp[i].iload, ram_m[a[i][6:0]]);
               done[i] = 1'b1;
               t[i] = cyc;
            end
         end
         @(posedge CLK);
      end
      for (int i = 0; i < CPUS; i++) begin
         if (mask[i]) ireq[i] <= '0;
      end
      // core 0 wins a tie, an earlier core 1 fetch is not broken off
      if (mask == 2'b11) check_flag("core1_first", t[1] < t[0], lead > 0);
   endtask

   // one data access from core r, the other cache answers the snoop
   task automatic daccess(input logic r, input logic wr, input addr_t a, input word_t wd);
      logic o, dirty, req_done, wb_done, answer, answered;
      word_t exp;
      o = !r;
      dirty = dbit[o][a[5:0]];
      exp = dirty ? dval[o][a[5:0]] : ram_m[a[6:0]];
      req_done = 1'b0;
      wb_done = !dirty;
      answered = 1'b0;
      if (dbit[r][a[5:0]]) begin
         if (wr) dval[r][a[5:0]] = wd; // own modified copy, a local hit
         return;
      end
      issued++;
      @(posedge CLK);
      dreq[r] <= '{dren: !wr, dwen: wr, daddr: a, dstore: wd};
      snoop_in[o] <= '{cctrans: 1'b1, ccwrite: 1'b0}; // still looking
      while (!(req_done && wb_done)) begin
         @(negedge CLK);
         answer = 1'b0;
         if (!answered && snoop_out[o].ccwait && snoop_out[o].ccsnoopaddr == a) begin
            check_flag("ccinv", snoop_out[o].ccinv, wr);
            answer = 1'b1;
            answered = 1'b1;
         end
         if (!req_done && !dresp[r].dwait) begin
            if (!wr) check_word("dload", dresp[r].dload, exp);
            req_done = 1'b1;
         end
         if (dirty && !dresp[o].dwait) wb_done = 1'b1; // writeback landed
         @(posedge CLK);
         if (answer) begin
            snoop_in[o] <= '{cctrans: 1'b0, ccwrite: dirty};
            dreq[o] <= '{dren: 1'b0, dwen: 1'b0, daddr: '0, dstore: exp};
         end
      end
      dreq[r] <= '0;
      dreq[o] <= '0;
      snoop_in[o] <= '0;
      if (dirty) begin
         ram_m[a[6:0]] = exp;
         dbit[o][a[5:0]] = 1'b0; // invalidated or shared now
         if (wr) begin
            dbit[r][a[5:0]] = 1'b1;
            dval[r][a[5:0]] = wd;
         end
      end else if (wr) begin
         ram_m[a[6:0]] = wd;
      end
   endtask

   function automatic addr_t daddr_rnd();
      return addr_t'(1 + rnd(6) % 63); // word 0 never used, ARBITRATE shows addr 0
   endfunction

   // run ends after 400 cycles per request
   always @(posedge CLK) begin
      cycles++;
      if (cycles > 400 * (issued + 1)) begin
         $display("timeout: a request never completed");
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      addr_t a;
      logic r;
      for (int i = 0; i < 128; i++) ram_m[i] = word_t'(i);
      for (int i = 0; i < 64; i++) begin
         dbit[0][i] = 1'b0;
         dbit[1][i] = 1'b0;
      end
      for (int i = 0; i < CPUS; i++) begin
         ireq[i] <= '0;
         dreq[i] <= '0;
         snoop_in[i] <= '0;
      end
      wait (nRST);
      @(negedge CLK);
      for (int i = 0; i < CPUS; i++) begin
         check_flag("iwait", iresp[i].iwait, 1'b1);
         check_flag("dwait", dresp[i].dwait, 1'b1);
         check_flag("ccwait", snoop_out[i].ccwait, 1'b0);
         check_flag("ccinv", snoop_out[i].ccinv, 1'b0);
      end
      report("reset");

      for (int n = 0; n < 20; n++) begin
         ifetch(2'(1 + rnd(2) % 3), rnd(2), addr_t'(rnd(7)), addr_t'(rnd(7)));
      end
      report("ifetch");

      for (int n = 0; n < 20; n++) begin
         a = daddr_rnd();
         daccess(1'(rnd(1)), 1'b1, a, word_t'(rnd(32)));
         daccess(1'(rnd(1)), 1'b0, a, '0); // read back from ram
      end
      report("mem_rw");

      for (int n = 0; n < 10; n++) begin
         r = 1'(rnd(1));
         a = daddr_rnd();
         if (!dbit[0][a[5:0]] && !dbit[1][a[5:0]]) begin
            dbit[!r][a[5:0]] = 1'b1; // other cache writes locally
            dval[!r][a[5:0]] = word_t'(rnd(32));
         end
         daccess(r, 1'b0, a, '0);
         daccess(1'(rnd(1)), 1'b0, a, '0); // ram holds the dirty word now
      end
      report("cache_to_cache");

      for (int n = 0; n < 10; n++) begin
         daccess(1'(rnd(1)), 1'b1, daddr_rnd(), word_t'(rnd(32)));
      end
      report("invalidate");

      for (int n = 0; n < 30; n++) begin
         fork
            ifetch(2'(1 + rnd(2) % 3), rnd(2), addr_t'(64 + rnd(6)),
                   addr_t'(64 + rnd(6)));
            daccess(1'(rnd(1)), 1'(rnd(1)), daddr_rnd(), word_t'(rnd(32)));
         join
      end
      report("mixed");

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
